//--- compile.f
common/ising_pkg.sv
spin_array/coupled_cell.sv
spin_array/shorted_cell.sv
spin_array/spin_delay_line.sv
spin_array/spin_array.sv
verilog/weight_port.sv
verilog/ising_core.sv
tb/tb_ising_core.sv

//--- Makefile
# Verilator build and run of the ising core testbench.

VERILATOR ?= verilator
TOP       ?= tb_ising_core
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= All tests passed!

.PHONY: sim clean

# the run passes only if the pass message shows up in the output.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- tb/tb_ising_core.sv
// ising core testbench: random weight bus and spin traffic checked against a model.

`timescale 1ns/1ns
`default_nettype none

module tb_ising_core import ising_pkg::*; ();

    localparam int clk_period     = 40;
    localparam int planned_cycles = 5 + 64 + 60 + 64 + 40 + 64 + 37 + 200 + 150 + 10 + 36 + 93;
    localparam int margin_cycles  = 200;

    logic        clk;
    logic        reset;
    logic        wr_en;
    logic [31:0] wr_addr;
    logic [31:0] wdata;
    logic [31:0] rd_addr;
    logic [31:0] rdata;
    logic        run;
    logic        spin_load;
    spin_vec_t   spin_init;
    spin_vec_t   spins;

    // reference model state.
    weight_t     m_w [spin_count][spin_count];  // symmetric with biases on the diagonal.
    spin_vec_t   m_dly [loop_delay];
    spin_vec_t   m_spins;
    logic [31:0] m_rdata;

    int          errors;
    int          checks;
    spin_vec_t   held;

    ising_core uut (
        .clk       (clk),
        .reset     (reset),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wdata     (wdata),
        .rd_addr   (rd_addr),
        .rdata     (rdata),
        .run       (run),
        .spin_load (spin_load),
        .spin_init (spin_init),
        .spins     (spins)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #((planned_cycles + margin_cycles) * clk_period);
        $display("timeout: the run did not finish within %0d cycles",
                 planned_cycles + margin_cycles);
        $display("Test failures found");
        $finish;
    end

    // **********************************************************************
    // address helpers
    // **********************************************************************
    function automatic logic [31:0] make_addr(input logic [7:0] mask,
                                              input logic [10:0] dst,
                                              input logic [10:0] src);
        return {mask, dst, src, 2'b00};
    endfunction

    function automatic logic [31:0] good_addr();
        return make_addr(weight_addr_mask, 11'($urandom % spin_count),
                         11'($urandom % spin_count));
    endfunction

    function automatic logic [31:0] bad_addr();
        logic [7:0]  mask;
        logic [10:0] dst;
        logic [10:0] src;
        mask = weight_addr_mask;
        dst  = 11'($urandom % spin_count);
        src  = 11'($urandom % spin_count);
        case ($urandom % 3)
            0: begin
                mask = 8'($urandom);
                if (mask == weight_addr_mask) mask = ~mask;
            end
            1: dst = 11'(spin_count + $urandom % (2048 - spin_count));
            default: src = 11'(spin_count + $urandom % (2048 - spin_count));
        endcase
        return make_addr(mask, dst, src);
    endfunction

    function automatic logic addr_valid(input logic [31:0] a);
        return (a[31:24] == weight_addr_mask) && (int'(a[23:13]) < spin_count) &&
               (int'(a[12:2]) < spin_count);
    endfunction

    // **********************************************************************
    // reference model
    // **********************************************************************
    function automatic int local_field(input int i);
        int f;
        f = int'(m_w[i][i]);
        for (int j = 0; j < spin_count; j++) begin
            if (j != i) begin
                if (m_dly[loop_delay-1][j]) f = f + int'(m_w[i][j]);
                else f = f - int'(m_w[i][j]);
            end
        end
        return f;
    endfunction

    task automatic model_edge();
        spin_vec_t nxt;
        int        f;
        nxt = m_spins;
        if (reset) begin
            foreach (m_w[r, c]) m_w[r][c] = '0;
            foreach (m_dly[k]) m_dly[k] = '0;
            m_spins = '0;
            m_rdata = '0;
        end else begin
            if (addr_valid(rd_addr)) m_rdata = int'(m_w[rd_addr[23:13]][rd_addr[12:2]]);
            else m_rdata = '0;
            if (spin_load) begin
                nxt = spin_init;
            end else if (run) begin
                for (int i = 0; i < spin_count; i++) begin
                    f = local_field(i);
                    if (f > 0) nxt[i] = 1'b1;
                    else if (f < 0) nxt[i] = 1'b0;
                end
            end
            for (int k = loop_delay - 1; k > 0; k--) m_dly[k] = m_dly[k-1];
            m_dly[0] = m_spins;
            if (wr_en && addr_valid(wr_addr)) begin
                m_w[wr_addr[23:13]][wr_addr[12:2]] = weight_t'(wdata[weight_w-1:0]);
                m_w[wr_addr[12:2]][wr_addr[23:13]] = weight_t'(wdata[weight_w-1:0]);
            end
            m_spins = nxt;
        end
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected,
                     actual);
        end
    endtask

    // model at the edge, compare 1 ns later, return at the drive point.
    task automatic step();
        @(posedge clk);
        model_edge();
        #1;
        check("spins", 32'(m_spins), 32'(spins));
        check("rdata", m_rdata, rdata);
        check("delayed_spins", 32'(m_dly[loop_delay-1]), 32'(uut.delayed_spins));
        #1;
    endtask

    task automatic read_all();
        wr_en = 1'b0;
        for (int i = 0; i < spin_count; i++) begin
            for (int j = 0; j < spin_count; j++) begin
                rd_addr = make_addr(weight_addr_mask, 11'(i), 11'(j));
                step();
            end
        end
        rd_addr = '0;
    endtask

    task automatic write_all_cells(input logic zero);
        wr_en = 1'b1;
        for (int i = 0; i < spin_count; i++) begin
            for (int j = i; j < spin_count; j++) begin
                wr_addr = make_addr(weight_addr_mask, 11'(i), 11'(j));
                wdata   = zero ? 32'd0 : $urandom;
                step();
            end
        end
        wr_en = 1'b0;
    endtask

    // **********************************************************************
    // stimulus
    // **********************************************************************
    initial begin
        void'($urandom(3));
        errors    = 0;
        checks    = 0;
        reset     = 1'b1;
        wr_en     = 1'b0;
        wr_addr   = '0;
        wdata     = '0;
        rd_addr   = '0;
        run       = 1'b0;
        spin_load = 1'b0;
        spin_init = '0;
        repeat (5) step();
        reset = 1'b0;

        read_all();                            // reset state.

        for (int n = 0; n < 60; n++) begin
            wr_en   = 1'b1;
            wr_addr = good_addr();
            wdata   = $urandom;
            case ($urandom % 3)
                0: rd_addr = wr_addr;          // same cycle returns the old value.
                1: rd_addr = make_addr(wr_addr[31:24], wr_addr[12:2], wr_addr[23:13]);
                default: rd_addr = good_addr();
            endcase
            step();
        end
        read_all();

        for (int n = 0; n < 40; n++) begin
            wr_en   = 1'b1;
            wr_addr = bad_addr();
            wdata   = $urandom;
            rd_addr = bad_addr();
            step();
        end
        read_all();                            // nothing may have changed.

        write_all_cells(1'b0);
        spin_load = 1'b1;
        spin_init = spin_vec_t'($urandom);
        step();
        spin_load = 1'b0;
        run       = 1'b1;
        repeat (200) step();

        for (int n = 0; n < 150; n++) begin
            run       = 1'($urandom % 2);
            spin_load = ($urandom % 4) == 0;
            spin_init = spin_vec_t'($urandom);
            step();
        end
        run       = 1'b0;
        spin_load = 1'b0;
        held      = m_spins;
        repeat (10) begin
            step();
            check("spins", 32'(held), 32'(spins));
        end

        // zero field keeps every loaded spin.
        write_all_cells(1'b1);
        repeat (3) begin
            spin_load = 1'b1;
            spin_init = spin_vec_t'($urandom);
            held      = spin_init;
            step();
            spin_load = 1'b0;
            run       = 1'b1;
            repeat (30) begin
                step();
                check("spins", 32'(held), 32'(spins));
            end
            run = 1'b0;
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/ising_core.sv
// ising core: weight bus port, spin matrix and spin feedback delay.

`timescale 1ns/1ns
`default_nettype none

module ising_core import ising_pkg::*; (
    input  logic        clk,
    input  logic        reset,

    // weight bus.
    input  logic        wr_en,
    input  logic [31:0] wr_addr,
    input  logic [31:0] wdata,
    input  logic [31:0] rd_addr,
    output logic [31:0] rdata,

    // spin control.
    input  logic        run,
    input  logic        spin_load,
    input  spin_vec_t   spin_init,
    output spin_vec_t   spins
);

    weight_wr_t weight_wr;
    weight_rd_t weight_rd;
    weight_t    rd_weight;
    spin_vec_t  delayed_spins;

    weight_port u_weight_port (
        .clk       (clk),
        .reset     (reset),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wdata     (wdata),
        .rd_addr   (rd_addr),
        .rd_weight (rd_weight),
        .weight_wr (weight_wr),
        .weight_rd (weight_rd),
        .rdata     (rdata)
    );

    spin_array u_spin_array (
        .clk           (clk),
        .reset         (reset),
        .weight_wr     (weight_wr),
        .weight_rd     (weight_rd),
        .delayed_spins (delayed_spins),
        .run           (run),
        .spin_load     (spin_load),
        .spin_init     (spin_init),
        .spins         (spins),
        .rd_weight     (rd_weight)
    );

    // spins come back into the matrix loop_delay cycles late.
    spin_delay_line #(
        .depth (loop_delay)
    ) u_spin_delay_line (
        .clk       (clk),
        .reset     (reset),
        .spins_in  (spins),
        .spins_out (delayed_spins)
    );

endmodule

`default_nettype wire

//--- verilog/weight_port.sv
// weight port: decodes bus addresses into weight writes and registered reads.

`timescale 1ns/1ns
`default_nettype none

module weight_port import ising_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        wr_en,
    input  logic [31:0] wr_addr,
    input  logic [31:0] wdata,
    input  logic [31:0] rd_addr,
    input  weight_t     rd_weight,
    output weight_wr_t  weight_wr,
    output weight_rd_t  weight_rd,
    output logic [31:0] rdata
);

    logic wr_ok;
    logic rd_ok;

    // mask byte matches and both indices name a real spin.
    function automatic logic addr_ok(input logic [31:0] addr);
        logic mask_hit;
        logic dst_hit;
        logic src_hit;
        mask_hit = (addr[addr_mask_lsb +: 8] == weight_addr_mask);
        dst_hit  = (addr[addr_dst_lsb +: addr_idx_w] < addr_idx_w'(spin_count));
        src_hit  = (addr[addr_src_lsb +: addr_idx_w] < addr_idx_w'(spin_count));
        return mask_hit && dst_hit && src_hit;
    endfunction

    assign wr_ok = addr_ok(wr_addr);
    assign rd_ok = addr_ok(rd_addr);

    // ********************************************************************
    // write and read requests
    // ********************************************************************
    always_comb begin
        weight_wr.en     = wr_en && wr_ok;
        weight_wr.row    = wr_addr[addr_dst_lsb +: spin_idx_w];  // destination.
        weight_wr.col    = wr_addr[addr_src_lsb +: spin_idx_w];  // source.
        weight_wr.weight = wdata[weight_w-1:0];
    end

    always_comb begin
        weight_rd.row = rd_addr[addr_dst_lsb +: spin_idx_w];
        weight_rd.col = rd_addr[addr_src_lsb +: spin_idx_w];
    end

    // ********************************************************************
    // read data
    // ********************************************************************
    // rd_weight still holds the old value during a same-cycle write.
    always_ff @(posedge clk) begin
        if (reset) begin
            rdata <= '0;
        end else if (rd_ok) begin
            rdata <= {{(32-weight_w){rd_weight[weight_w-1]}}, rd_weight};  // sign extend.
        end else begin
            rdata <= '0;
        end
    end

endmodule

`default_nettype wire

//--- spin_array/spin_array.sv
// spin array: matrix of coupled and shorted cells with row field sums.

`timescale 1ns/1ns
`default_nettype none

module spin_array import ising_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  weight_wr_t weight_wr,
    input  weight_rd_t weight_rd,
    input  spin_vec_t  delayed_spins,
    input  logic       run,
    input  logic       spin_load,
    input  spin_vec_t  spin_init,
    output spin_vec_t  spins,
    output weight_t    rd_weight
);

    field_t    terms   [spin_count][spin_count];  // [row][neighbor].
    weight_t   pair_w  [spin_count][spin_count];  // upper triangle only.
    weight_t   biases  [spin_count];
    field_t    row_sum [spin_count];
    spin_idx_t rd_lo;
    spin_idx_t rd_hi;

    // ********************************************************************
    // cell matrix
    // ********************************************************************
    for (genvar i = 0; i < spin_count; i++) begin : g_row
        for (genvar j = 0; j < spin_count; j++) begin : g_col
            if (i < j) begin : g_pair
                coupled_cell #(
                    .row_idx (i),
                    .col_idx (j)
                ) u_coupled_cell (
                    .clk       (clk),
                    .reset     (reset),
                    .weight_wr (weight_wr),
                    .spin_a    (delayed_spins[i]),
                    .spin_b    (delayed_spins[j]),
                    .weight    (pair_w[i][j]),
                    .term_a    (terms[i][j]),
                    .term_b    (terms[j][i])
                );
            end else begin : g_lower
                assign pair_w[i][j] = '0;             // lower half never read.
                if (i == j) begin : g_self
                    assign terms[i][i] = '0;          // no self coupling.
                end
            end
        end

        shorted_cell #(
            .idx (i)
        ) u_shorted_cell (
            .clk           (clk),
            .reset         (reset),
            .weight_wr     (weight_wr),
            .coupling_sum  (row_sum[i]),
            .spin_init_bit (spin_init[i]),
            .run           (run),
            .spin_load     (spin_load),
            .bias          (biases[i]),
            .spin          (spins[i])
        );
    end

    // ********************************************************************
    // local field sums
    // ********************************************************************
    always_comb begin
        for (int r = 0; r < spin_count; r++) begin
            row_sum[r] = '0;
            for (int c = 0; c < spin_count; c++) begin
                row_sum[r] = row_sum[r] + terms[r][c];
            end
        end
    end

    // ********************************************************************
    // weight read-back
    // ********************************************************************
    always_comb begin
        if (weight_rd.row > weight_rd.col) begin
            rd_lo = weight_rd.col;                    // pair stored once.
            rd_hi = weight_rd.row;
        end else begin
            rd_lo = weight_rd.row;
            rd_hi = weight_rd.col;
        end
        if (rd_lo == rd_hi) begin
            rd_weight = biases[rd_lo];
        end else begin
            rd_weight = pair_w[rd_lo][rd_hi];
        end
    end

endmodule

`default_nettype wire

//--- spin_array/spin_delay_line.sv
// spin delay line: register chain on the spin feedback path.

`timescale 1ns/1ns
`default_nettype none

module spin_delay_line import ising_pkg::*; #(
    parameter int depth = loop_delay
) (
    input  logic      clk,
    input  logic      reset,
    input  spin_vec_t spins_in,
    output spin_vec_t spins_out
);

    if (depth == 0) begin : g_pass
        assign spins_out = spins_in;
    end else begin : g_chain
        spin_vec_t stage [depth];

        // shifts every cycle, run or not.
        always_ff @(posedge clk) begin
            if (reset) begin
                for (int k = 0; k < depth; k++) begin
                    stage[k] <= '0;
                end
            end else begin
                stage[0] <= spins_in;
                for (int k = 1; k < depth; k++) begin
                    stage[k] <= stage[k-1];
                end
            end
        end

        assign spins_out = stage[depth-1];
    end

endmodule

`default_nettype wire

//--- spin_array/shorted_cell.sv
// shorted cell: diagonal bias storage and the spin update flip-flop.

`timescale 1ns/1ns
`default_nettype none

module shorted_cell import ising_pkg::*; #(
    parameter int idx = 0
) (
    input  logic       clk,
    input  logic       reset,
    input  weight_wr_t weight_wr,
    input  field_t     coupling_sum,
    input  logic       spin_init_bit,
    input  logic       run,
    input  logic       spin_load,
    output weight_t    bias,
    output logic       spin
);

    logic   bias_hit;
    field_t field;

    assign bias_hit = weight_wr.en &&
                      (weight_wr.row == spin_idx_t'(idx)) &&
                      (weight_wr.col == spin_idx_t'(idx));

    always_ff @(posedge clk) begin
        if (reset) begin
            bias <= '0;
        end else if (bias_hit) begin
            bias <= weight_wr.weight;
        end
    end

    assign field = coupling_sum + field_t'(bias);

    // ********************************************************************
    // spin update
    // ********************************************************************
    // load wins over run; zero field keeps the spin.
    always_ff @(posedge clk) begin
        if (reset) begin
            spin <= 1'b0;
        end else if (spin_load) begin
            spin <= spin_init_bit;
        end else if (run) begin
            if (field > 0) begin
                spin <= 1'b1;
            end else if (field < 0) begin
                spin <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- spin_array/coupled_cell.sv
// coupled cell: one pair weight and its signed field terms for both rows.

`timescale 1ns/1ns
`default_nettype none

module coupled_cell import ising_pkg::*; #(
    parameter int row_idx = 0,
    parameter int col_idx = 1
) (
    input  logic       clk,
    input  logic       reset,
    input  weight_wr_t weight_wr,
    input  logic       spin_a,
    input  logic       spin_b,
    output weight_t    weight,
    output field_t     term_a,
    output field_t     term_b
);

    logic   hit;
    field_t weight_ext;

    // either address order names this pair.
    assign hit = weight_wr.en &&
                 ((weight_wr.row == spin_idx_t'(row_idx) &&
                   weight_wr.col == spin_idx_t'(col_idx)) ||
                  (weight_wr.row == spin_idx_t'(col_idx) &&
                   weight_wr.col == spin_idx_t'(row_idx)));

    always_ff @(posedge clk) begin
        if (reset) begin
            weight <= '0;
        end else if (hit) begin
            weight <= weight_wr.weight;
        end
    end

    // widen before negating so -8 does not wrap.
    assign weight_ext = field_t'(weight);
    assign term_a     = spin_b ? weight_ext : -weight_ext;  // into row_idx.
    assign term_b     = spin_a ? weight_ext : -weight_ext;  // into col_idx.

endmodule

`default_nettype wire

//--- common/ising_pkg.sv
// ising package: array sizes, bus address layout and shared weight bus types.

`default_nettype none

package ising_pkg;

    // ********************************************************************
    // sizes
    // ********************************************************************
    localparam int spin_count = 8;
    localparam int spin_idx_w = 3;
    localparam int weight_w   = 4;
    localparam int field_w    = 8;        // bias plus seven weights.
    localparam int loop_delay = 2;        // feedback cycles.

    // ********************************************************************
    // weight bus address layout
    // ********************************************************************
    localparam logic [7:0] weight_addr_mask = 8'hA5;
    localparam int addr_mask_lsb = 24;    // top byte.
    localparam int addr_dst_lsb  = 13;    // destination in 23:13.
    localparam int addr_src_lsb  = 2;     // source in 12:2.
    localparam int addr_idx_w    = 11;

    // ********************************************************************
    // types
    // ********************************************************************
    typedef logic [spin_count-1:0]      spin_vec_t;   // 1 is up, 0 is down.
    typedef logic [spin_idx_w-1:0]      spin_idx_t;
    typedef logic signed [weight_w-1:0] weight_t;
    typedef logic signed [field_w-1:0]  field_t;

    typedef struct packed {
        logic      en;
        spin_idx_t row;
        spin_idx_t col;
        weight_t   weight;
    } weight_wr_t;

    typedef struct packed {
        spin_idx_t row;
        spin_idx_t col;
    } weight_rd_t;

endpackage

`default_nettype wire
